// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pipeline_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/pipeline_core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_core_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 stall,
  input logic                 flush,
  input logic                 mem_we,
  input logic                 wb_valid,
  input riscv_pkg::xlen_t     pc_out,
  input riscv_pkg::reg_addr_t wb_rd
);

  // Squashed slots never reach the data memory as a store
  store_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !mem_we ##1 !mem_we ##1 !mem_we)
    else $error("mem_we rose for a slot squashed by a flush");

  x0_never_retires: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_rd != '0))
    else $error("wb_valid high with wb_rd equal to x0");

  // Load and branch cannot share the execute slot
  stall_flush_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(stall && flush))
    else $error("stall and flush high in the same cycle");

  stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable(pc_out))
    else $error("pc_out changed across a stall");

endmodule

bind pipeline_core pipeline_core_sva u_sva (
  .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .mem_we(mem_we),
  .wb_valid(wb_valid), .pc_out(pc_out), .wb_rd(wb_rd)
);

`default_nettype wire

// File: sim/pipeline_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_core_tb;

  localparam riscv_pkg::xlen_t RESET_PC = 64'h0;
  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 256;
  localparam int NUM_TESTS    = 5;
  localparam int RESET_CYCLES = 10;
  localparam int QUIET_CYCLES = 12;

  logic                 clk;
  logic                 rst_n;
  riscv_pkg::xlen_t     pc_out;
  riscv_pkg::inst_t     inst_in;
  riscv_pkg::xlen_t     mem_addr;
  riscv_pkg::xlen_t     mem_wdata;
  logic                 mem_we;
  riscv_pkg::xlen_t     mem_rdata;
  logic                 wb_valid;
  riscv_pkg::reg_addr_t wb_rd;
  riscv_pkg::xlen_t     wb_data;

  riscv_pkg::inst_t     imem [IMEM_WORDS];
  riscv_pkg::xlen_t     dmem [DMEM_WORDS];
  riscv_pkg::xlen_t     test_start [NUM_TESTS];
  string                test_name [NUM_TESTS];
  int                   remaining [NUM_TESTS];
  int                   test_errors [NUM_TESTS];
  riscv_pkg::reg_addr_t exp_rd [$];
  riscv_pkg::xlen_t     exp_data [$];
  int                   exp_test [$];
  int prog_len = 0;
  int checks = 0;
  int errors = 0;
  int tests_done = 0;
  int cycles = 0;
  int limit = 0;

  tb_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (.clk, .rst_n);

  pipeline_core #(.RESET_PC(RESET_PC)) dut (
    .clk, .rst_n, .pc_out, .inst_in, .mem_addr, .mem_wdata, .mem_we,
    .mem_rdata, .wb_valid, .wb_rd, .wb_data
  );

  // Both memories answer in the same cycle
  assign inst_in   = imem[pc_out[7:2]];
  assign mem_rdata = dmem[mem_addr[10:3]];

  always @(posedge clk) begin
    if (mem_we) dmem[mem_addr[10:3]] <= mem_wdata;
  end

  function automatic riscv_pkg::xlen_t fill_word(riscv_pkg::xlen_t addr);
    return {addr[31:0] ^ 32'hda7a_5a5a, addr[63:32] ^ ~addr[31:0]};
  endfunction

  function automatic riscv_pkg::inst_t r_type(logic [6:0] f7, logic [2:0] f3,
                                              int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], riscv_pkg::OPC_OP};
  endfunction

  function automatic riscv_pkg::inst_t i_type(logic [6:0] opc, logic [2:0] f3,
                                              int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // SD only
  function automatic riscv_pkg::inst_t s_type(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], riscv_pkg::OPC_STORE};
  endfunction

  function automatic riscv_pkg::inst_t b_type(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
            riscv_pkg::OPC_BRANCH};
  endfunction

  function automatic riscv_pkg::inst_t u_type(int rd, int imm);
    return {imm[19:0], rd[4:0], riscv_pkg::OPC_LUI};
  endfunction

  function automatic riscv_pkg::inst_t j_type(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], riscv_pkg::OPC_JAL};
  endfunction

  task automatic emit(input riscv_pkg::inst_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic mark_test(input int k, input string name);
    test_start[k] = RESET_PC + riscv_pkg::xlen_t'(prog_len * 4);
    test_name[k]  = name;
  endtask

  task automatic build_program();
    int r1;
    int r2;
    int r3;
    int r4;
    r1 = $urandom();
    r2 = $urandom();
    r3 = $urandom();
    r4 = $urandom();
    // Dependent chain hits memory and write-back forwarding
    mark_test(0, "alu_chain");
    emit(u_type(1, r1));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 1, 1, r2));
    emit(u_type(2, r3));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 2, 2, r4));
    emit(r_type(7'h00, 3'b000, 3, 1, 2));
    emit(r_type(7'h20, 3'b000, 4, 3, 1));
    emit(r_type(7'h00, 3'b111, 5, 4, 3));
    emit(r_type(7'h00, 3'b110, 6, 5, 4));
    emit(r_type(7'h00, 3'b100, 7, 6, 5));
    emit(r_type(7'h00, 3'b010, 8, 7, 6));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 9, 8, -5));
    mark_test(1, "load_use");
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 10, 0, 64));
    emit(s_type(7, 10, 8));
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b011, 11, 10, 8));
    emit(r_type(7'h00, 3'b000, 12, 11, 1));
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b011, 13, 10, 16));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 14, 13, 1));
    // x15 and x17 sit on wrong paths only
    mark_test(2, "branches");
    emit(b_type(3'b000, 1, 1, 12));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 15, 0, 1));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 15, 0, 2));
    emit(b_type(3'b001, 1, 1, 8));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 16, 0, 3));
    emit(b_type(3'b001, 16, 0, 8));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 17, 0, 4));
    emit(b_type(3'b000, 16, 0, 8));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 18, 0, 5));
    mark_test(3, "jal");
    emit(j_type(20, 12));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 21, 0, 1));
    // Wrong-path store after the jump
    emit(s_type(1, 10, 8));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 22, 20, 0));
    mark_test(4, "x0_handling");
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 0, 0, 123));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 23, 0, 7));
    emit(r_type(7'h00, 3'b000, 0, 1, 2));
    emit(r_type(7'h00, 3'b000, 24, 0, 1));
    emit(j_type(0, 0));
  endtask

  function automatic int test_of(riscv_pkg::xlen_t pc);
    int t = 0;
    for (int k = 0; k < NUM_TESTS; k++) begin
      if (pc >= test_start[k]) t = k;
    end
    return t;
  endfunction

  // Architectural model, one instruction per step, no pipeline
  function automatic void run_reference();
    riscv_pkg::xlen_t xr [32];
    riscv_pkg::xlen_t ref_mem [riscv_pkg::xlen_t];
    riscv_pkg::xlen_t pc;
    riscv_pkg::xlen_t next_pc;
    riscv_pkg::xlen_t a;
    riscv_pkg::xlen_t b;
    riscv_pkg::xlen_t res;
    riscv_pkg::xlen_t imm_i;
    riscv_pkg::xlen_t imm_s;
    riscv_pkg::xlen_t imm_b;
    riscv_pkg::xlen_t imm_j;
    riscv_pkg::inst_t w;
    logic             wr;
    for (int i = 0; i < 32; i++) xr[i] = '0;
    pc = RESET_PC;
    for (int step = 0; step < 200; step++) begin
      w       = imem[pc[7:2]];
      a       = xr[w[19:15]];
      b       = xr[w[24:20]];
      imm_i   = {{52{w[31]}}, w[31:20]};
      imm_s   = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b   = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j   = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      next_pc = pc + 64'd4;
      wr      = 1'b1;
      res     = '0;
      case (w[6:0])
        riscv_pkg::OPC_OP: begin
          case ({w[30], w[14:12]})
            4'b0000: res = a + b;
            4'b1000: res = a - b;
            4'b0111: res = a & b;
            4'b0110: res = a | b;
            4'b0100: res = a ^ b;
            4'b0010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: wr = 1'b0;
          endcase
        end
        riscv_pkg::OPC_OP_IMM: res = a + imm_i;
        riscv_pkg::OPC_LUI:    res = {{32{w[31]}}, w[31:12], 12'h000};
        riscv_pkg::OPC_LOAD: begin
          res = ref_mem.exists(a + imm_i) ? ref_mem[a + imm_i] : fill_word(a + imm_i);
        end
        riscv_pkg::OPC_STORE: begin
          ref_mem[a + imm_s] = b;
          wr = 1'b0;
        end
        riscv_pkg::OPC_BRANCH: begin
          wr = 1'b0;
          if ((a == b) != w[12]) next_pc = pc + imm_b;
        end
        riscv_pkg::OPC_JAL: begin
          res     = pc + 64'd4;
          next_pc = pc + imm_j;
        end
        default: wr = 1'b0;
      endcase
      if (wr && w[11:7] != 5'd0) begin
        xr[w[11:7]] = res;
        exp_rd.push_back(w[11:7]);
        exp_data.push_back(res);
        exp_test.push_back(test_of(pc));
        remaining[test_of(pc)]++;
      end
      // Program ends on a jump to itself
      if (next_pc == pc) break;
      pc = next_pc;
    end
  endfunction

  task automatic check_retire();
    riscv_pkg::reg_addr_t erd;
    riscv_pkg::xlen_t     edata;
    int                   t;
    if (exp_rd.size() == 0) begin
      $display("Unexpected retirement of a write to x%0d after the last expected one", wb_rd);
      errors++;
      return;
    end
    erd   = exp_rd.pop_front();
    edata = exp_data.pop_front();
    t     = exp_test.pop_front();
    checks++;
    if (wb_rd != erd) begin
      $display("[ERROR] wb_rd: got 0x%h, expected 0x%h (%s)", wb_rd, erd, test_name[t]);
      errors++;
      test_errors[t]++;
    end
    if (wb_data != edata) begin
      $display("[ERROR] wb_data: got 0x%h, expected 0x%h (x%0d, %s)",
               wb_data, edata, erd, test_name[t]);
      errors++;
      test_errors[t]++;
    end
    remaining[t]--;
    if (remaining[t] == 0) begin
      tests_done++;
      $display("[TEST] %s: %0d errors, %s", test_name[t], test_errors[t],
               (test_errors[t] == 0) ? "ok" : "FAILED");
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  always @(posedge clk) begin
    if (rst_n && wb_valid) check_retire();
  end

  initial begin
    logic timed_out;
    void'($urandom(32'hf551));
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = 32'h0000_0013;
    for (int i = 0; i < DMEM_WORDS; i++) dmem[i] <= fill_word(riscv_pkg::xlen_t'(i * 8));
    for (int k = 0; k < NUM_TESTS; k++) begin
      remaining[k]   = 0;
      test_errors[k] = 0;
    end
    build_program();
    run_reference();
    limit = RESET_CYCLES + 8 * exp_rd.size() + QUIET_CYCLES;
    while (exp_rd.size() != 0 && cycles < limit) @(negedge clk);
    timed_out = (exp_rd.size() != 0);
    if (timed_out) begin
      $display("Timeout: %0d expected writes still missing after %0d cycles",
               exp_rd.size(), cycles);
    end else begin
      // Late wrong-path writes would show up here
      repeat (QUIET_CYCLES) @(negedge clk);
    end
    $display("Checks: %0d, errors: %0d, tests finished: %0d of %0d",
             checks, errors, tests_done, NUM_TESTS);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: source/core_control.sv
`timescale 1ns/10ps
`default_nettype none

module core_control (
  input  riscv_pkg::inst_t     id_inst,
  input  riscv_pkg::reg_addr_t ex_rs1,
  input  riscv_pkg::reg_addr_t ex_rs2,
  input  riscv_pkg::reg_addr_t ex_rd,
  input  logic                 ex_mem_read,
  input  riscv_pkg::reg_addr_t mem_rd,
  input  logic                 mem_reg_write,
  input  riscv_pkg::reg_addr_t wb_rd,
  input  logic                 wb_reg_write,
  input  logic                 branch_taken,
  output logic                 stall,
  output logic                 flush,
  output riscv_pkg::fwd_sel_t  fwd_a,
  output riscv_pkg::fwd_sel_t  fwd_b,
  output riscv_pkg::reg_addr_t id_rs1,
  output riscv_pkg::reg_addr_t id_rs2,
  output riscv_pkg::reg_addr_t id_rd,
  output riscv_pkg::xlen_t     id_imm,
  output riscv_pkg::alu_op_t   id_alu_op,
  output logic                 id_alu_src_imm,
  output logic                 id_mem_read,
  output logic                 id_mem_write,
  output logic                 id_reg_write,
  output riscv_pkg::wb_sel_t   id_wb_sel,
  output logic                 id_branch,
  output logic                 id_branch_ne,
  output logic                 id_jump
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  riscv_pkg::xlen_t imm_i;
  riscv_pkg::xlen_t imm_s;
  riscv_pkg::xlen_t imm_b;
  riscv_pkg::xlen_t imm_u;
  riscv_pkg::xlen_t imm_j;

  assign opcode = id_inst[6:0];
  assign funct3 = id_inst[14:12];
  assign id_rd  = id_inst[11:7];

  // Sign-extended immediates for each format
  assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
  assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                  id_inst[11:8], 1'b0};
  assign imm_u = {{32{id_inst[31]}}, id_inst[31:12], 12'b0};
  assign imm_j = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                  id_inst[30:21], 1'b0};

  // Unused sources stay at x0 so they never stall or forward
  always_comb begin
    id_rs1         = '0;
    id_rs2         = '0;
    id_imm         = imm_i;
    id_alu_op      = riscv_pkg::ALU_ADD;
    id_alu_src_imm = 1'b0;
    id_mem_read    = 1'b0;
    id_mem_write   = 1'b0;
    id_reg_write   = 1'b0;
    id_wb_sel      = riscv_pkg::WB_ALU;
    id_branch      = 1'b0;
    id_branch_ne   = 1'b0;
    id_jump        = 1'b0;
    case (opcode)
      riscv_pkg::OPC_OP: begin
        id_rs1       = id_inst[19:15];
        id_rs2       = id_inst[24:20];
        id_reg_write = 1'b1;
        case (funct3)
          riscv_pkg::F3_ADD_SUB:
            id_alu_op = id_inst[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
          riscv_pkg::F3_SLT: id_alu_op = riscv_pkg::ALU_SLT;
          riscv_pkg::F3_XOR: id_alu_op = riscv_pkg::ALU_XOR;
          riscv_pkg::F3_OR:  id_alu_op = riscv_pkg::ALU_OR;
          riscv_pkg::F3_AND: id_alu_op = riscv_pkg::ALU_AND;
          default:           id_reg_write = 1'b0;
        endcase
      end
      riscv_pkg::OPC_OP_IMM: begin
        if (funct3 == riscv_pkg::F3_ADD_SUB) begin
          id_rs1         = id_inst[19:15];
          id_alu_src_imm = 1'b1;
          id_reg_write   = 1'b1;
        end
      end
      riscv_pkg::OPC_LUI: begin
        id_imm         = imm_u;
        id_alu_op      = riscv_pkg::ALU_PASS_B;
        id_alu_src_imm = 1'b1;
        id_reg_write   = 1'b1;
      end
      riscv_pkg::OPC_LOAD: begin
        if (funct3 == riscv_pkg::F3_DOUBLE) begin
          id_rs1         = id_inst[19:15];
          id_alu_src_imm = 1'b1;
          id_mem_read    = 1'b1;
          id_reg_write   = 1'b1;
          id_wb_sel      = riscv_pkg::WB_MEM;
        end
      end
      riscv_pkg::OPC_STORE: begin
        if (funct3 == riscv_pkg::F3_DOUBLE) begin
          id_rs1         = id_inst[19:15];
          id_rs2         = id_inst[24:20];
          id_imm         = imm_s;
          id_alu_src_imm = 1'b1;
          id_mem_write   = 1'b1;
        end
      end
      riscv_pkg::OPC_BRANCH: begin
        if (funct3 == riscv_pkg::F3_BEQ || funct3 == riscv_pkg::F3_BNE) begin
          id_rs1       = id_inst[19:15];
          id_rs2       = id_inst[24:20];
          id_imm       = imm_b;
          id_branch    = 1'b1;
          id_branch_ne = (funct3 == riscv_pkg::F3_BNE);
        end
      end
      riscv_pkg::OPC_JAL: begin
        id_imm       = imm_j;
        id_jump      = 1'b1;
        id_reg_write = 1'b1;
        id_wb_sel    = riscv_pkg::WB_PC4;
      end
      default: begin
      end
    endcase
  end

  // Load in execute feeding the decode instruction
  assign stall = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);
  assign flush = branch_taken;

  // Memory stage wins over write-back
  function automatic riscv_pkg::fwd_sel_t fwd_pick(
    input riscv_pkg::reg_addr_t rs,
    input riscv_pkg::reg_addr_t m_rd,
    input logic                 m_we,
    input riscv_pkg::reg_addr_t w_rd,
    input logic                 w_we
  );
    if (rs == '0) return riscv_pkg::FWD_REG;
    if (m_we && m_rd == rs) return riscv_pkg::FWD_MEM;
    if (w_we && w_rd == rs) return riscv_pkg::FWD_WB;
    return riscv_pkg::FWD_REG;
  endfunction

  always_comb begin
    fwd_a = fwd_pick(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    fwd_b = fwd_pick(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
  end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  riscv_pkg::reg_addr_t id_rs1,
  input  riscv_pkg::reg_addr_t id_rs2,
  input  riscv_pkg::reg_addr_t id_rd,
  input  riscv_pkg::xlen_t     id_imm,
  input  riscv_pkg::alu_op_t   id_alu_op,
  input  logic                 id_alu_src_imm,
  input  logic                 id_mem_read,
  input  logic                 id_mem_write,
  input  logic                 id_reg_write,
  input  riscv_pkg::wb_sel_t   id_wb_sel,
  input  logic                 id_branch,
  input  logic                 id_branch_ne,
  input  logic                 id_jump,
  input  riscv_pkg::xlen_t     id_pc,
  input  riscv_pkg::xlen_t     rdata1,
  input  riscv_pkg::xlen_t     rdata2,
  input  riscv_pkg::fwd_sel_t  fwd_a,
  input  riscv_pkg::fwd_sel_t  fwd_b,
  input  riscv_pkg::xlen_t     wb_data,
  output riscv_pkg::reg_addr_t ex_rs1,
  output riscv_pkg::reg_addr_t ex_rs2,
  output riscv_pkg::reg_addr_t ex_rd,
  output logic                 ex_mem_read,
  output logic                 branch_taken,
  output riscv_pkg::xlen_t     redirect_pc,
  output riscv_pkg::reg_addr_t mem_rd,
  output logic                 mem_reg_write,
  output riscv_pkg::wb_sel_t   mem_wb_sel,
  output riscv_pkg::xlen_t     mem_alu_result,
  output riscv_pkg::xlen_t     mem_pc4,
  output riscv_pkg::xlen_t     mem_addr,
  output riscv_pkg::xlen_t     mem_wdata,
  output logic                 mem_we
);

  riscv_pkg::xlen_t   ex_imm;
  riscv_pkg::xlen_t   ex_pc;
  riscv_pkg::xlen_t   ex_rdata1;
  riscv_pkg::xlen_t   ex_rdata2;
  riscv_pkg::alu_op_t ex_alu_op;
  riscv_pkg::wb_sel_t ex_wb_sel;
  logic               ex_alu_src_imm;
  logic               ex_mem_write;
  logic               ex_reg_write;
  logic               ex_branch;
  logic               ex_branch_ne;
  logic               ex_jump;
  riscv_pkg::xlen_t   mem_fwd_val;
  riscv_pkg::xlen_t   op_a;
  riscv_pkg::xlen_t   rs2_val;
  riscv_pkg::xlen_t   op_b;
  riscv_pkg::xlen_t   alu_out;

  // Decode/execute register, bubble on stall or flush
  always_ff @(posedge clk) begin
    if (!rst_n || flush || stall) begin
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_branch    <= 1'b0;
      ex_jump      <= 1'b0;
    end else begin
      ex_mem_read  <= id_mem_read;
      ex_mem_write <= id_mem_write;
      ex_reg_write <= id_reg_write;
      ex_branch    <= id_branch;
      ex_jump      <= id_jump;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs1         <= id_rs1;
    ex_rs2         <= id_rs2;
    ex_rd          <= id_rd;
    ex_imm         <= id_imm;
    ex_pc          <= id_pc;
    ex_rdata1      <= rdata1;
    ex_rdata2      <= rdata2;
    ex_alu_op      <= id_alu_op;
    ex_alu_src_imm <= id_alu_src_imm;
    ex_wb_sel      <= id_wb_sel;
    ex_branch_ne   <= id_branch_ne;
  end

  // A JAL in memory forwards its link address
  assign mem_fwd_val = (mem_wb_sel == riscv_pkg::WB_PC4) ? mem_pc4 : mem_alu_result;

  function automatic riscv_pkg::xlen_t fwd_mux(
    input riscv_pkg::fwd_sel_t sel,
    input riscv_pkg::xlen_t    reg_val,
    input riscv_pkg::xlen_t    mem_val,
    input riscv_pkg::xlen_t    wb_val
  );
    case (sel)
      riscv_pkg::FWD_MEM: return mem_val;
      riscv_pkg::FWD_WB:  return wb_val;
      default:            return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a    = fwd_mux(fwd_a, ex_rdata1, mem_fwd_val, wb_data);
    rs2_val = fwd_mux(fwd_b, ex_rdata2, mem_fwd_val, wb_data);
    op_b    = ex_alu_src_imm ? ex_imm : rs2_val;
  end

  always_comb begin
    case (ex_alu_op)
      riscv_pkg::ALU_SUB:    alu_out = op_a - op_b;
      riscv_pkg::ALU_AND:    alu_out = op_a & op_b;
      riscv_pkg::ALU_OR:     alu_out = op_a | op_b;
      riscv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      riscv_pkg::ALU_SLT:    alu_out = {63'b0, $signed(op_a) < $signed(op_b)};
      riscv_pkg::ALU_PASS_B: alu_out = op_b;
      default:               alu_out = op_a + op_b;
    endcase
  end

  // BEQ and BNE compare the forwarded sources
  assign branch_taken = ex_jump || (ex_branch && ((op_a == rs2_val) != ex_branch_ne));
  assign redirect_pc  = ex_pc + ex_imm;

  // Execute/memory register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_reg_write <= 1'b0;
      mem_we        <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_we        <= ex_mem_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd         <= ex_rd;
    mem_wb_sel     <= ex_wb_sel;
    mem_alu_result <= alu_out;
    mem_pc4        <= ex_pc + 64'd4;
    mem_wdata      <= rs2_val;
  end

  assign mem_addr = mem_alu_result;

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
  parameter riscv_pkg::xlen_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  logic             flush,
  input  riscv_pkg::xlen_t redirect_pc,
  input  riscv_pkg::inst_t inst_in,
  output riscv_pkg::xlen_t pc_out,
  output riscv_pkg::inst_t id_inst,
  output riscv_pkg::xlen_t id_pc
);

  riscv_pkg::xlen_t pc_next;

  // Redirect beats stall, static not-taken otherwise
  always_comb begin
    if (flush) begin
      pc_next = redirect_pc;
    end else if (stall) begin
      pc_next = pc_out;
    end else begin
      pc_next = pc_out + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_out <= RESET_PC;
    end else begin
      pc_out <= pc_next;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      id_inst <= riscv_pkg::NOP_INST;
    end else if (!stall) begin
      id_inst <= inst_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_pc <= pc_out;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  riscv_pkg::reg_addr_t mem_rd,
  input  logic                 mem_reg_write,
  input  riscv_pkg::wb_sel_t   mem_wb_sel,
  input  riscv_pkg::xlen_t     mem_alu_result,
  input  riscv_pkg::xlen_t     mem_pc4,
  input  riscv_pkg::xlen_t     mem_rdata,
  output riscv_pkg::reg_addr_t wb_rd,
  output logic                 wb_reg_write,
  output riscv_pkg::xlen_t     wb_data
);

  riscv_pkg::wb_sel_t wb_sel;
  riscv_pkg::xlen_t   wb_alu_result;
  riscv_pkg::xlen_t   wb_pc4;
  riscv_pkg::xlen_t   wb_rdata;

  // x0 writes never retire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_reg_write <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write && (mem_rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    wb_rd         <= mem_rd;
    wb_sel        <= mem_wb_sel;
    wb_alu_result <= mem_alu_result;
    wb_pc4        <= mem_pc4;
    wb_rdata      <= mem_rdata;
  end

  always_comb begin
    case (wb_sel)
      riscv_pkg::WB_MEM: wb_data = wb_rdata;
      riscv_pkg::WB_PC4: wb_data = wb_pc4;
      default:           wb_data = wb_alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: source/pipeline_core.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_core #(
  parameter riscv_pkg::xlen_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output riscv_pkg::xlen_t     pc_out,
  input  riscv_pkg::inst_t     inst_in,
  output riscv_pkg::xlen_t     mem_addr,
  output riscv_pkg::xlen_t     mem_wdata,
  output logic                 mem_we,
  input  riscv_pkg::xlen_t     mem_rdata,
  output logic                 wb_valid,
  output riscv_pkg::reg_addr_t wb_rd,
  output riscv_pkg::xlen_t     wb_data
);

  logic                 stall;
  logic                 flush;
  riscv_pkg::fwd_sel_t  fwd_a;
  riscv_pkg::fwd_sel_t  fwd_b;
  riscv_pkg::inst_t     id_inst;
  riscv_pkg::xlen_t     id_pc;
  riscv_pkg::reg_addr_t id_rs1;
  riscv_pkg::reg_addr_t id_rs2;
  riscv_pkg::reg_addr_t id_rd;
  riscv_pkg::xlen_t     id_imm;
  riscv_pkg::alu_op_t   id_alu_op;
  logic                 id_alu_src_imm;
  logic                 id_mem_read;
  logic                 id_mem_write;
  logic                 id_reg_write;
  riscv_pkg::wb_sel_t   id_wb_sel;
  logic                 id_branch;
  logic                 id_branch_ne;
  logic                 id_jump;
  riscv_pkg::xlen_t     rdata1;
  riscv_pkg::xlen_t     rdata2;
  riscv_pkg::reg_addr_t ex_rs1;
  riscv_pkg::reg_addr_t ex_rs2;
  riscv_pkg::reg_addr_t ex_rd;
  logic                 ex_mem_read;
  logic                 branch_taken;
  riscv_pkg::xlen_t     redirect_pc;
  riscv_pkg::reg_addr_t mem_rd;
  logic                 mem_reg_write;
  riscv_pkg::wb_sel_t   mem_wb_sel;
  riscv_pkg::xlen_t     mem_alu_result;
  riscv_pkg::xlen_t     mem_pc4;
  logic                 wb_reg_write;

  assign wb_valid = wb_reg_write;

  core_control u_control (
    .id_inst, .ex_rs1, .ex_rs2, .ex_rd, .ex_mem_read,
    .mem_rd, .mem_reg_write, .wb_rd, .wb_reg_write, .branch_taken,
    .stall, .flush, .fwd_a, .fwd_b,
    .id_rs1, .id_rs2, .id_rd, .id_imm, .id_alu_op, .id_alu_src_imm,
    .id_mem_read, .id_mem_write, .id_reg_write, .id_wb_sel,
    .id_branch, .id_branch_ne, .id_jump
  );

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk, .rst_n, .stall, .flush, .redirect_pc, .inst_in,
    .pc_out, .id_inst, .id_pc
  );

  // Read in decode, written from write-back
  reg_file u_regs (
    .clk, .rst_n,
    .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
    .we(wb_reg_write), .wdata(wb_data),
    .rdata1, .rdata2
  );

  execute_stage u_execute (
    .clk, .rst_n, .stall, .flush,
    .id_rs1, .id_rs2, .id_rd, .id_imm, .id_alu_op, .id_alu_src_imm,
    .id_mem_read, .id_mem_write, .id_reg_write, .id_wb_sel,
    .id_branch, .id_branch_ne, .id_jump, .id_pc,
    .rdata1, .rdata2, .fwd_a, .fwd_b, .wb_data,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_mem_read, .branch_taken, .redirect_pc,
    .mem_rd, .mem_reg_write, .mem_wb_sel, .mem_alu_result, .mem_pc4,
    .mem_addr, .mem_wdata, .mem_we
  );

  mem_wb_stage u_mem_wb (
    .clk, .rst_n, .mem_rd, .mem_reg_write, .mem_wb_sel,
    .mem_alu_result, .mem_pc4, .mem_rdata,
    .wb_rd, .wb_reg_write, .wb_data
  );

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  riscv_pkg::reg_addr_t rs1,
  input  riscv_pkg::reg_addr_t rs2,
  input  riscv_pkg::reg_addr_t rd,
  input  logic                 we,
  input  riscv_pkg::xlen_t     wdata,
  output riscv_pkg::xlen_t     rdata1,
  output riscv_pkg::xlen_t     rdata2
);

  riscv_pkg::xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Same-cycle write shows up on the read side
  always_comb begin
    if (rs1 == '0) rdata1 = '0;
    else if (we && rd == rs1) rdata1 = wdata;
    else rdata1 = regs[rs1];
    if (rs2 == '0) rdata2 = '0;
    else if (we && rd == rs2) rdata2 = wdata;
    else rdata2 = regs[rs2];
  end

endmodule

`default_nettype wire

// File: source/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [1:0]  fwd_sel_t;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_DOUBLE  = 3'b011;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_SUB    = 3'd1;
  localparam alu_op_t ALU_AND    = 3'd2;
  localparam alu_op_t ALU_OR     = 3'd3;
  localparam alu_op_t ALU_XOR    = 3'd4;
  localparam alu_op_t ALU_SLT    = 3'd5;
  localparam alu_op_t ALU_PASS_B = 3'd6;

  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_MEM = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;

  localparam fwd_sel_t FWD_REG = 2'd0;
  localparam fwd_sel_t FWD_MEM = 2'd1;
  localparam fwd_sel_t FWD_WB  = 2'd2;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// File: sources.f
source/riscv_pkg.sv
source/core_control.sv
source/fetch_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/pipeline_core.sv
sim/tb_clock_gen.sv
sim/pipeline_core_sva.sv
sim/pipeline_core_tb.sv
